// File: design/mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// Operand and low product width
`define MUL_OPERAND_W 32
// Carry-save row, twice the operand
`define MUL_ROW_W     64
`define MUL_PP_COUNT  16   // One per radix-4 digit
// Zero-extension bit plus room for the doubled multiple
`define MUL_PP_W      34

`endif

// File: design/mul_data_pkg.sv
`include "mul_cfg.svh"

package mul_data_pkg;

    // Multiplicand or multiplier
    typedef logic [`MUL_OPERAND_W-1:0] operand_t;

    // Low half of the product
    typedef logic [`MUL_OPERAND_W-1:0] product_t;

    // One row of the carry-save tree
    typedef logic [`MUL_ROW_W-1:0] row_t;

    // Booth multiple before sign extension and shift
    typedef logic [`MUL_PP_W-1:0] pp_t;

endpackage

// File: design/mul_tree_pkg.sv
`include "mul_cfg.svh"

package mul_tree_pkg;

    // Overlapping multiplier bits {b[2i+1], b[2i], b[2i-1]}
    typedef logic [2:0] booth_digit_t;

    // Row count at each tree level, three rows become two
    typedef mul_data_pkg::row_t [`MUL_PP_COUNT-1:0] rows16_t;
    typedef mul_data_pkg::row_t [10:0]              rows11_t;
    typedef mul_data_pkg::row_t [7:0]               rows8_t;   // First register
    typedef mul_data_pkg::row_t [5:0]               rows6_t;
    typedef mul_data_pkg::row_t [3:0]               rows4_t;   // Second register
    typedef mul_data_pkg::row_t [2:0]               rows3_t;
    typedef mul_data_pkg::row_t [1:0]               rows2_t;   // Into the final adder

endpackage

// File: design/booth_pp_gen.sv
`timescale 1ns/1ps
`include "mul_cfg.svh"

module booth_pp_gen (
    input  mul_data_pkg::operand_t     multiplicand,
    input  mul_data_pkg::operand_t     multiplier,
    output wire mul_tree_pkg::rows16_t rows
);

    localparam int SIGN_EXT_W = `MUL_ROW_W - `MUL_PP_W;
    localparam int ZERO_EXT_W = `MUL_PP_W - `MUL_OPERAND_W;

    // Multiplier with the implied zero below bit 0
    logic [`MUL_OPERAND_W:0] mult_ext;

    // Pick 0, +-1x or +-2x of the zero-extended multiplicand
    function automatic mul_data_pkg::pp_t select_pp(
        input mul_tree_pkg::booth_digit_t digit,
        input mul_data_pkg::operand_t     mcand
    );
        mul_data_pkg::pp_t one_x;
        mul_data_pkg::pp_t two_x;

        one_x = {{ZERO_EXT_W{1'b0}}, mcand};
        two_x = {{(ZERO_EXT_W-1){1'b0}}, mcand, 1'b0};
        case (digit)
            3'b001, 3'b010: select_pp = one_x;
            3'b011:         select_pp = two_x;
            3'b100:         select_pp = -two_x;
            3'b101, 3'b110: select_pp = -one_x;
            default:        select_pp = '0;      // 000 and 111
        endcase
    endfunction

    assign mult_ext = {multiplier, 1'b0};

    // Top digit reads b[31] as a sign, which only disturbs the upper half
    for (genvar i = 0; i < `MUL_PP_COUNT; i++) begin : g_pp
        mul_data_pkg::pp_t  pp;
        mul_data_pkg::row_t pp_row;

        assign pp     = select_pp(mult_ext[2*i +: 3], multiplicand);
        assign pp_row = {{SIGN_EXT_W{pp[`MUL_PP_W-1]}}, pp};   // Sign extend to a row
        assign rows[i] = pp_row << (2*i);                      // Weight 4^i
    end

endmodule

// File: design/csa_level.sv
`timescale 1ns/1ps
`include "mul_cfg.svh"

module csa_level #(
    parameter  int ROWS_IN  = 3,
    localparam int ROWS_OUT = 2*(ROWS_IN/3) + ROWS_IN%3
) (
    input  mul_data_pkg::row_t [ROWS_IN-1:0]       rows_in,
    output wire mul_data_pkg::row_t [ROWS_OUT-1:0] rows_out
);

    localparam int GROUPS = ROWS_IN / 3;
    localparam int LEFT   = ROWS_IN % 3;

    // Each full group of three rows gives a sum row and a carry row
    for (genvar g = 0; g < GROUPS; g++) begin : g_group
        mul_data_pkg::row_t      a;
        mul_data_pkg::row_t      b;
        mul_data_pkg::row_t      c;
        wire mul_data_pkg::row_t sum;
        wire mul_data_pkg::row_t carry;

        assign a = rows_in[3*g];
        assign b = rows_in[3*g+1];
        assign c = rows_in[3*g+2];

        // Carry lands one column up
        assign carry[0] = 1'b0;

        for (genvar col = 0; col < `MUL_ROW_W; col++) begin : g_col
            assign sum[col] = a[col] ^ b[col] ^ c[col];
            // Carry out of the top column falls off the row
            if (col < `MUL_ROW_W-1) begin : g_cy
                assign carry[col+1] = (a[col] & b[col]) | (b[col] & c[col])
                                    | (a[col] & c[col]);
            end
        end

        assign rows_out[2*g]   = sum;
        assign rows_out[2*g+1] = carry;
    end

    // Leftover rows go straight to the next level
    for (genvar k = 0; k < LEFT; k++) begin : g_pass
        assign rows_out[2*GROUPS+k] = rows_in[3*GROUPS+k];
    end

endmodule

// File: design/tree_segment.sv
`timescale 1ns/1ps

module tree_segment #(
    parameter  int ROWS_IN  = 16,
    localparam int ROWS_MID = 2*(ROWS_IN/3) + ROWS_IN%3,
    localparam int ROWS_OUT = 2*(ROWS_MID/3) + ROWS_MID%3
) (
    input  logic                                clk,
    input  logic                                RST_n,
    input  logic                                stall,
    input  logic                                valid_in,
    input  mul_data_pkg::row_t [ROWS_IN-1:0]    rows_in,
    output logic                                valid_out,
    output mul_data_pkg::row_t [ROWS_OUT-1:0]   rows_out
);

    // After the first carry-save level
    mul_data_pkg::row_t [ROWS_MID-1:0] rows_mid;
    // After the second, ready to register
    mul_data_pkg::row_t [ROWS_OUT-1:0] rows_red;

    csa_level #(
        .ROWS_IN (ROWS_IN)
    ) u_lvl0 (
        .rows_in  (rows_in),
        .rows_out (rows_mid)
    );

    csa_level #(
        .ROWS_IN (ROWS_MID)
    ) u_lvl1 (
        .rows_in  (rows_mid),
        .rows_out (rows_red)
    );

    // Stage register, frozen while stalled
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            valid_out <= 1'b0;
            rows_out  <= '0;
        end else if (!stall) begin
            valid_out <= valid_in;
            rows_out  <= rows_red;   // Row data moves with its valid bit
        end
    end

endmodule

// File: design/tree_final.sv
`timescale 1ns/1ps
`include "mul_cfg.svh"

module tree_final (
    input  mul_tree_pkg::rows4_t   rows_in,
    output mul_data_pkg::product_t product
);

    mul_tree_pkg::rows3_t rows_l0;
    // Sum and carry rows for the adder
    mul_tree_pkg::rows2_t rows_l1;

    csa_level #(
        .ROWS_IN (4)
    ) u_lvl0 (
        .rows_in  (rows_in),
        .rows_out (rows_l0)
    );

    csa_level #(
        .ROWS_IN (3)
    ) u_lvl1 (
        .rows_in  (rows_l0),
        .rows_out (rows_l1)
    );

    // Carry-propagate add, only the low half reaches the port
    assign product = rows_l1[0][`MUL_OPERAND_W-1:0] + rows_l1[1][`MUL_OPERAND_W-1:0];

endmodule

// File: design/booth_mul_top.sv
`timescale 1ns/1ps

module booth_mul_top (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   stall,
    input  logic                   in_valid,
    input  mul_data_pkg::operand_t multiplicand,
    input  mul_data_pkg::operand_t multiplier,
    output logic                   out_valid,
    output mul_data_pkg::product_t product
);

    mul_tree_pkg::rows16_t pp_rows;     // Booth rows, combinational
    mul_tree_pkg::rows8_t  seg0_rows;
    mul_tree_pkg::rows4_t  seg1_rows;
    logic                  seg0_valid;

    booth_pp_gen u_pp_gen (
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .rows         (pp_rows)
    );

    // Sixteen rows down to eight, first register
    tree_segment #(
        .ROWS_IN (16)
    ) u_seg0 (
        .clk       (clk),
        .RST_n     (RST_n),
        .stall     (stall),
        .valid_in  (in_valid),
        .rows_in   (pp_rows),
        .valid_out (seg0_valid),
        .rows_out  (seg0_rows)
    );

    // Eight rows down to four, second register
    tree_segment #(
        .ROWS_IN (8)
    ) u_seg1 (
        .clk       (clk),
        .RST_n     (RST_n),
        .stall     (stall),
        .valid_in  (seg0_valid),
        .rows_in   (seg0_rows),
        .valid_out (out_valid),
        .rows_out  (seg1_rows)
    );

    tree_final u_final (
        .rows_in (seg1_rows),
        .product (product)
    );

endmodule

// File: bench/booth_mul_tb.sv
`timescale 1ns/1ps

module booth_mul_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int IDLE_CYCLES    = 6;
    localparam int N_CORNERS      = 15;
    localparam int N_RANDOM       = 300;
    localparam int N_STALL_CYCLES = 400;
    localparam int STALL_FACTOR   = 4;     // Worst case cycles per planned transaction
    localparam int WATCHDOG_NS    = (RESET_CYCLES + IDLE_CYCLES + N_CORNERS + N_RANDOM
                                    + N_STALL_CYCLES + 16) * STALL_FACTOR * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'h5f28_753b;

    logic                   clk = 1'b0;
    logic                   RST_n;
    logic                   stall;
    logic                   in_valid;
    mul_data_pkg::operand_t multiplicand;
    mul_data_pkg::operand_t multiplier;
    logic                   out_valid;
    mul_data_pkg::product_t product;

    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;
    int          accepted;
    int          results;

    // What the DUT saw on the coming edge
    logic                   edge_rst;
    logic                   edge_stall;
    logic                   edge_accept;
    mul_data_pkg::product_t edge_product;

    // Outputs from one cycle back for the hold check
    logic                   prev_valid;
    mul_data_pkg::product_t prev_product;

    mul_data_pkg::product_t exp_q[$];   // Expected products in order
    int                     age_q[$];   // Non-stalled edges seen by each entry

    booth_mul_top u_dut (
        .clk          (clk),
        .RST_n        (RST_n),
        .stall        (stall),
        .in_valid     (in_valid),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .out_valid    (out_valid),
        .product      (product)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Low half of the full unsigned product
    function automatic mul_data_pkg::product_t low_product(
        input mul_data_pkg::operand_t a,
        input mul_data_pkg::operand_t b
    );
        logic [63:0] full;
        full = {32'h0, a} * {32'h0, b};
        return full[31:0];
    endfunction

    task automatic drive(
        input logic                   v,
        input logic                   s,
        input mul_data_pkg::operand_t a,
        input mul_data_pkg::operand_t b
    );
        @(posedge clk);
        #1;
        in_valid     = v;
        stall        = s;
        multiplicand = a;
        multiplier   = b;
    endtask

    task automatic check_outputs();
        logic expect_valid;
        expect_valid = (age_q.size() > 0) && (age_q[0] >= 2);
        if (edge_stall) begin
            // Frozen pipeline
            assert (out_valid == prev_valid) else begin
                value_errors++;
                $display("[ERROR] t=%0t out_valid expected %0b actual %0b",
                         $time, prev_valid, out_valid);
            end
            assert (product == prev_product) else begin
                value_errors++;
                $display("[ERROR] t=%0t product expected %h actual %h",
                         $time, prev_product, product);
            end
        end else begin
            assert (out_valid == expect_valid) else begin
                value_errors++;
                $display("[ERROR] t=%0t out_valid expected %0b actual %0b",
                         $time, expect_valid, out_valid);
            end
            if (expect_valid) begin
                if (out_valid) begin
                    assert (product == exp_q[0]) else begin
                        value_errors++;
                        $display("[ERROR] t=%0t product expected %h actual %h",
                                 $time, exp_q[0], product);
                    end
                    results++;
                end
                void'(exp_q.pop_front());
                void'(age_q.pop_front());
            end
        end
        assert (accepted > 0 || !out_valid) else begin
            other_errors++;
            $display("out_valid went high at t=%0t before any pair was accepted", $time);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (edge_rst) begin
            if (!edge_stall) begin
                foreach (age_q[i]) age_q[i] = age_q[i] + 1;
                if (edge_accept) begin
                    exp_q.push_back(edge_product);
                    age_q.push_back(1);
                    accepted++;
                end
            end
            check_outputs();
        end
        prev_valid   = out_valid;
        prev_product = product;
        edge_rst     = RST_n;
        edge_stall   = stall;
        edge_accept  = RST_n && in_valid && !stall;
        edge_product = low_product(multiplicand, multiplier);
    end

    task automatic run_idle();
        repeat (IDLE_CYCLES) drive(1'b0, 1'b0, '0, '0);
    endtask

    task automatic apply(input mul_data_pkg::operand_t a, input mul_data_pkg::operand_t b);
        drive(1'b1, 1'b0, a, b);
    endtask

    // Multiplier patterns 0, 3333, 5555, 6666, aaaa, cccc, ffff cover all eight digits
    task automatic run_corners();
        apply(32'h0000_0000, 32'h0000_0000);
        apply(32'h0000_0000, 32'hffff_ffff);
        apply(32'hffff_ffff, 32'h0000_0000);
        apply(32'hffff_ffff, 32'hffff_ffff);
        apply(32'h8000_0000, 32'h8000_0000);
        apply(32'h8000_0000, 32'h0000_0001);
        apply(32'h0000_0001, 32'h8000_0000);
        apply(32'hffff_ffff, 32'h8000_0000);
        apply(32'hdead_beef, 32'h5555_5555);
        apply(32'hffff_ffff, 32'haaaa_aaaa);
        apply(32'h8000_0000, 32'h3333_3333);
        apply(32'h1234_5678, 32'hcccc_cccc);
        apply(32'hffff_ffff, 32'h6666_6666);
        apply(32'h7fff_ffff, 32'hffff_ffff);
        apply(32'hffff_ffff, 32'h0000_0001);
    endtask

    task automatic run_random();
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < N_RANDOM; n++) begin
            take_bits(32, a);
            take_bits(32, b);
            apply(a, b);
        end
    endtask

    task automatic run_stalls();
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        logic        s;
        logic        v;
        for (int n = 0; n < N_STALL_CYCLES; n++) begin
            take_bits(2, sel);
            s = (sel[1:0] == 2'b00);    // Stall about one cycle in four
            take_bits(1, sel);
            v = sel[0];
            take_bits(32, a);
            take_bits(32, b);
            drive(v, s, a, b);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) drive(1'b0, 1'b0, '0, '0);
        repeat (4) drive(1'b0, 1'b0, '0, '0);   // Catch late duplicates
    endtask

    task automatic finish_run();
        assert (results == accepted) else begin
            other_errors++;
            $display("Accepted %0d pairs but saw %0d results", accepted, results);
        end
        $display("Summary: %0d value errors, %0d other errors, %0d pairs, %0d results",
                 value_errors, other_errors, accepted, results);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        lfsr_state   = LFSR_SEED;
        RST_n        = 1'b0;
        stall        = 1'b0;
        in_valid     = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        value_errors = 0;
        other_errors = 0;
        accepted     = 0;
        results      = 0;
        edge_rst     = 1'b0;
        edge_stall   = 1'b0;
        edge_accept  = 1'b0;
        edge_product = '0;
        prev_valid   = 1'b0;
        prev_product = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        RST_n = 1'b1;
        run_idle();
        run_corners();
        run_random();
        run_stalls();
        drain();
        finish_run();
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, the run did not finish in %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/mul_data_pkg.sv
design/mul_tree_pkg.sv
design/booth_pp_gen.sv
design/csa_level.sv
design/tree_segment.sv
design/tree_final.sv
design/booth_mul_top.sv
bench/booth_mul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Booth multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --assert --timing \
    -f vlog.f \
    --top-module booth_mul_tb \
    -Mdir "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vbooth_mul_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
